//--- Bender.yml
package:
  name: io_port_hub

export_include_dirs:
  - .

sources:
  - iobus_pkg.sv
  - io_addr_decoder.sv
  - io_dev_strobe.sv
  - io_read_router.sv
  - io_port_hub.sv
  - target: test
    files:
      - tb_clock_gen.sv
      - io_port_hub_checker.sv
      - io_port_hub_tb.sv

//--- files.f
+incdir+.
iobus_pkg.sv
io_addr_decoder.sv
io_dev_strobe.sv
io_read_router.sv
io_port_hub.sv
tb_clock_gen.sv
io_port_hub_checker.sv
io_port_hub_tb.sv

//--- io_addr_decoder.sv
`timescale 1ns/1ps
`default_nettype none

`include "iobus_consts.svh"

module io_addr_decoder
	import iobus_pkg::*;
(
	input  wire logic     clk_sys,
	input  wire logic     rst_n,

	input  wire logic     io_req_valid,
	input  wire io_req_t  io_req,

	output logic          s1_valid,
	output logic          s1_write,
	output dev_sel_t      s1_sel,
	output dev_cmd_t      s1_cmd
);

	dev_sel_t sel_d;

	// True when addr falls in the 2**bits ports starting at base
	function automatic logic win_hit(io_addr_t addr, io_addr_t base, int unsigned bits);
		return (addr >> bits) == (base >> bits);
	endfunction

	// ------------------------------------------------------------
	// Window compare, one select bit per device
	// ------------------------------------------------------------
	always_comb begin
		sel_d = '0;

		sel_d[DEV_HDD0]     = win_hit(io_req.addr, `IO_BASE_HDD0, `IO_BITS_HDD0);
		sel_d[DEV_HDD1]     = win_hit(io_req.addr, `IO_BASE_HDD1, `IO_BITS_HDD1);
		sel_d[DEV_FLOPPY]   = win_hit(io_req.addr, `IO_BASE_FLOPPY, `IO_BITS_FLOPPY);
		sel_d[DEV_HDD1_EXT] = win_hit(io_req.addr, `IO_BASE_HDD1_EXT, `IO_BITS_HDD1_EXT);

		sel_d[DEV_DMA]      = win_hit(io_req.addr, `IO_BASE_DMA_SLAVE, `IO_BITS_DMA_SLAVE)
		                    | win_hit(io_req.addr, `IO_BASE_DMA_PAGE, `IO_BITS_DMA_PAGE)
		                    | win_hit(io_req.addr, `IO_BASE_DMA_MASTER, `IO_BITS_DMA_MASTER);

		sel_d[DEV_PIC]      = win_hit(io_req.addr, `IO_BASE_PIC_MASTER, `IO_BITS_PIC_MASTER)
		                    | win_hit(io_req.addr, `IO_BASE_PIC_SLAVE, `IO_BITS_PIC_SLAVE);

		sel_d[DEV_PIT]      = win_hit(io_req.addr, `IO_BASE_PIT, `IO_BITS_PIT);

		// Keyboard data and status at 60h, system control port A at 92h
		sel_d[DEV_PS2]      = win_hit(io_req.addr, `IO_BASE_PS2_IO, `IO_BITS_PS2_IO)
		                    | win_hit(io_req.addr, `IO_BASE_PS2_CTL, `IO_BITS_PS2_CTL);

		sel_d[DEV_RTC]      = win_hit(io_req.addr, `IO_BASE_RTC, `IO_BITS_RTC);

		sel_d[DEV_SOUND]    = win_hit(io_req.addr, `IO_BASE_SB, `IO_BITS_SB)
		                    | win_hit(io_req.addr, `IO_BASE_FM, `IO_BITS_FM);

		sel_d[DEV_UART]     = win_hit(io_req.addr, `IO_BASE_UART, `IO_BITS_UART)
		                    | win_hit(io_req.addr, `IO_BASE_MPU, `IO_BITS_MPU);

		sel_d[DEV_VGA]      = win_hit(io_req.addr, `IO_BASE_VGA_B, `IO_BITS_VGA_B)
		                    | win_hit(io_req.addr, `IO_BASE_VGA_C, `IO_BITS_VGA_C)
		                    | win_hit(io_req.addr, `IO_BASE_VGA_D, `IO_BITS_VGA_D);

		sel_d[DEV_JOY]      = win_hit(io_req.addr, `IO_BASE_JOY, `IO_BITS_JOY); // Single port
	end

	// ------------------------------------------------------------
	// Stage 1 register
	// ------------------------------------------------------------
	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			s1_valid <= 1'b0;
		end else begin
			s1_valid <= io_req_valid;
		end
	end

	always_ff @(posedge clk_sys) begin
		s1_write     <= io_req.write;
		s1_sel       <= sel_d; // All zero for an unmapped port
		s1_cmd.addr  <= io_req.addr;
		s1_cmd.wdata <= io_req.wdata;
	end

endmodule

`default_nettype wire

//--- io_dev_strobe.sv
`timescale 1ns/1ps
`default_nettype none

module io_dev_strobe
	import iobus_pkg::*;
(
	input  wire logic     clk_sys,
	input  wire logic     rst_n,

	input  wire logic     s1_valid,
	input  wire logic     s1_write,
	input  wire dev_sel_t s1_sel,
	input  wire dev_cmd_t s1_cmd,

	output dev_sel_t      dev_rd,
	output dev_sel_t      dev_wr,
	output dev_cmd_t      dev_cmd,

	output logic          s2_valid,
	output logic          s2_write,
	output dev_sel_t      s2_sel
);

	// ------------------------------------------------------------
	// Per-device strobes
	// ------------------------------------------------------------
	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			dev_rd   <= '0;
			dev_wr   <= '0;
			s2_valid <= 1'b0;
		end else begin
			dev_rd   <= (s1_valid && !s1_write) ? s1_sel : '0;
			dev_wr   <= (s1_valid && s1_write) ? s1_sel : '0;
			s2_valid <= s1_valid; // Unmapped accesses still need a done
		end
	end

	// Command stays put between accesses so idle devices see no toggling
	always_ff @(posedge clk_sys) begin
		if (s1_valid) begin
			dev_cmd <= s1_cmd;
		end
	end

	always_ff @(posedge clk_sys) begin
		s2_write <= s1_write;
		s2_sel   <= s1_sel;
	end

endmodule

`default_nettype wire

//--- io_port_hub.sv
`timescale 1ns/1ps
`default_nettype none

module io_port_hub
	import iobus_pkg::*;
(
	input  wire logic       clk_sys,
	input  wire logic       rst_n,

	input  wire logic       io_req_valid,
	input  wire io_req_t    io_req,
	output logic            io_done,
	output io_rsp_t         io_rsp,

	output dev_sel_t        dev_rd,
	output dev_sel_t        dev_wr,
	output dev_cmd_t        dev_cmd,
	input  wire dev_rdata_t dev_rdata
);

	logic     s1_valid;
	logic     s1_write;
	dev_sel_t s1_sel;
	dev_cmd_t s1_cmd;

	logic     s2_valid;
	logic     s2_write;
	dev_sel_t s2_sel;

	// ------------------------------------------------------------
	// Decode, strobe, return
	// ------------------------------------------------------------
	io_addr_decoder u_addr_decoder (
		.clk_sys      (clk_sys),
		.rst_n        (rst_n),
		.io_req_valid (io_req_valid),
		.io_req       (io_req),
		.s1_valid     (s1_valid),
		.s1_write     (s1_write),
		.s1_sel       (s1_sel),
		.s1_cmd       (s1_cmd)
	);

	io_dev_strobe u_dev_strobe (
		.clk_sys  (clk_sys),
		.rst_n    (rst_n),
		.s1_valid (s1_valid),
		.s1_write (s1_write),
		.s1_sel   (s1_sel),
		.s1_cmd   (s1_cmd),
		.dev_rd   (dev_rd),
		.dev_wr   (dev_wr),
		.dev_cmd  (dev_cmd),
		.s2_valid (s2_valid),
		.s2_write (s2_write),
		.s2_sel   (s2_sel)
	);

	io_read_router u_read_router (
		.clk_sys   (clk_sys),
		.rst_n     (rst_n),
		.s2_valid  (s2_valid),
		.s2_write  (s2_write),
		.s2_sel    (s2_sel),
		.dev_rdata (dev_rdata),
		.io_done   (io_done),
		.io_rsp    (io_rsp)
	);

endmodule

`default_nettype wire

//--- io_port_hub_checker.sv
`timescale 1ns/1ps
`default_nettype none

`include "iobus_consts.svh"

module io_port_hub_checker
	import iobus_pkg::*;
(
	input  wire logic     clk_sys,
	input  wire logic     rst_n,
	input  wire logic     io_req_valid,
	input  wire logic     io_done,
	input  wire dev_sel_t dev_rd,
	input  wire dev_sel_t dev_wr
);

	int unsigned failures = 0; // Polled by the testbench

	// ------------------------------------------------------------
	// Strobe and handshake properties
	// ------------------------------------------------------------
	a_strobe_onehot: assert property (@(posedge clk_sys) disable iff (!rst_n)
		$onehot0(dev_rd) && $onehot0(dev_wr) && !((|dev_rd) && (|dev_wr)))
		else begin
			failures++;
			$error("dev_rd or dev_wr has more than one bit set");
		end

	a_done_follows_req: assert property (@(posedge clk_sys) disable iff (!rst_n)
		io_req_valid |-> ##`IO_DONE_LATENCY io_done)
		else begin
			failures++;
			$error("io_done missing after a request");
		end

	a_done_has_req: assert property (@(posedge clk_sys) disable iff (!rst_n)
		io_done |-> $past(io_req_valid, `IO_DONE_LATENCY))
		else begin
			failures++;
			$error("io_done without a matching request");
		end

	// Not disabled by reset, this one watches the reset itself
	a_quiet_in_reset: assert property (@(posedge clk_sys)
		!rst_n |-> (dev_rd == '0) && (dev_wr == '0) && !io_done)
		else begin
			failures++;
			$error("strobe or io_done active during reset");
		end

endmodule

bind io_port_hub io_port_hub_checker chk0 (
	.clk_sys      (clk_sys),
	.rst_n        (rst_n),
	.io_req_valid (io_req_valid),
	.io_done      (io_done),
	.dev_rd       (dev_rd),
	.dev_wr       (dev_wr)
);

`default_nettype wire

//--- io_port_hub_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "iobus_consts.svh"

module io_port_hub_tb
	import iobus_pkg::*;
();

	localparam int unsigned TIMEOUT_CYCLES = 20;
	localparam int unsigned BURST_LEN      = 64;

	typedef struct {
		io_addr_t    base;
		int unsigned bits;
		dev_id_e     dev;
	} window_t;

	typedef struct {
		io_addr_t addr;
		logic     write;
		io_data_t wdata;
		int       dev;   // -1 for an unmapped port
		io_data_t rdata;
	} vector_t;

	logic       clk_sys;
	logic       rst_n;
	logic       io_req_valid;
	io_req_t    io_req;
	logic       io_done;
	io_rsp_t    io_rsp;
	dev_sel_t   dev_rd;
	dev_sel_t   dev_wr;
	dev_cmd_t   dev_cmd;
	dev_rdata_t dev_rdata;

	int unsigned cycle_cnt = 0;
	int unsigned err_cnt = 0;
	vector_t     vectors[$];

	// Listed in device priority order
	window_t windows[21] = '{
		'{`IO_BASE_HDD0, `IO_BITS_HDD0, DEV_HDD0},
		'{`IO_BASE_HDD1, `IO_BITS_HDD1, DEV_HDD1},
		'{`IO_BASE_FLOPPY, `IO_BITS_FLOPPY, DEV_FLOPPY},
		'{`IO_BASE_HDD1_EXT, `IO_BITS_HDD1_EXT, DEV_HDD1_EXT},
		'{`IO_BASE_DMA_SLAVE, `IO_BITS_DMA_SLAVE, DEV_DMA},
		'{`IO_BASE_DMA_PAGE, `IO_BITS_DMA_PAGE, DEV_DMA},
		'{`IO_BASE_DMA_MASTER, `IO_BITS_DMA_MASTER, DEV_DMA},
		'{`IO_BASE_PIC_MASTER, `IO_BITS_PIC_MASTER, DEV_PIC},
		'{`IO_BASE_PIC_SLAVE, `IO_BITS_PIC_SLAVE, DEV_PIC},
		'{`IO_BASE_PIT, `IO_BITS_PIT, DEV_PIT},
		'{`IO_BASE_PS2_IO, `IO_BITS_PS2_IO, DEV_PS2},
		'{`IO_BASE_PS2_CTL, `IO_BITS_PS2_CTL, DEV_PS2},
		'{`IO_BASE_RTC, `IO_BITS_RTC, DEV_RTC},
		'{`IO_BASE_SB, `IO_BITS_SB, DEV_SOUND},
		'{`IO_BASE_FM, `IO_BITS_FM, DEV_SOUND},
		'{`IO_BASE_UART, `IO_BITS_UART, DEV_UART},
		'{`IO_BASE_MPU, `IO_BITS_MPU, DEV_UART},
		'{`IO_BASE_VGA_B, `IO_BITS_VGA_B, DEV_VGA},
		'{`IO_BASE_VGA_C, `IO_BITS_VGA_C, DEV_VGA},
		'{`IO_BASE_VGA_D, `IO_BITS_VGA_D, DEV_VGA},
		'{`IO_BASE_JOY, `IO_BITS_JOY, DEV_JOY}
	};

	tb_clock_gen clk0 (.clk_sys(clk_sys));

	io_port_hub dut0 (.*);

	always @(posedge clk_sys) begin
		cycle_cnt <= cycle_cnt + 1;
	end

	always @(negedge clk_sys) begin
		if (dut0.chk0.failures != 0) begin
			report_failure("an assertion in io_port_hub_checker failed");
		end
	end

	// ------------------------------------------------------------
	// Reference model
	// ------------------------------------------------------------
	function automatic io_data_t dev_word(int i);
		return {8'hC0 + 8'(i), 8'h5A, 8'(i * 3), 8'h11 * 8'(i + 1)}; // Low bytes all distinct
	endfunction

	function automatic int ref_dev(io_addr_t a);
		int lo;
		int hi;
		foreach (windows[w]) begin
			lo = int'(windows[w].base);
			hi = lo + (1 << windows[w].bits) - 1;
			if (int'(a) >= lo && int'(a) <= hi) begin
				return int'(windows[w].dev);
			end
		end
		return -1;
	endfunction

	function automatic dev_sel_t onehot(int dev);
		return (dev < 0) ? '0 : dev_sel_t'(1) << dev;
	endfunction

	function automatic vector_t make_vec(io_addr_t a, logic w, io_data_t d);
		vector_t v;
		io_data_t word;
		v.addr = a;
		v.write = w;
		v.wdata = d;
		v.dev = ref_dev(a);
		word = (v.dev < 0) ? 32'd0 : dev_word(v.dev);
		if (w) begin
			v.rdata = '0;
		end else if (v.dev < 0) begin
			v.rdata = {24'd0, `IO_UNMAPPED_BYTE};
		end else if (v.dev == int'(DEV_HDD0) || v.dev == int'(DEV_HDD1)) begin
			v.rdata = word; // IDE data ports are 32 bits wide
		end else begin
			v.rdata = {24'd0, word[7:0]};
		end
		return v;
	endfunction

	function automatic vector_t random_vec();
		io_addr_t a;
		a = ($urandom_range(1) != 0) ? io_addr_t'($urandom_range(16'h03FF)) : io_addr_t'($urandom);
		return make_vec(a, 1'($urandom_range(1)), $urandom);
	endfunction

	// ------------------------------------------------------------
	// Result checks
	// ------------------------------------------------------------
	task automatic report_failure(string what);
		err_cnt++;
		$display("%s", what);
		$display("SOME TESTS FAILED");
		$fatal(1, "stopped at the first error");
	endtask

	task automatic check_data(string name, io_data_t got, io_data_t exp);
		if (got !== exp) begin
			report_failure($sformatf("MISMATCH time=%0t %s got=%h expected=%h",
				$time, name, got, exp));
		end
	endtask

	task automatic check_sel(string name, dev_sel_t got, dev_sel_t exp);
		if (got !== exp) begin
			report_failure($sformatf("MISMATCH time=%0t %s got=%b expected=%b",
				$time, name, got, exp));
		end
	endtask

	task automatic check_cmd(string name, dev_cmd_t got, dev_cmd_t exp);
		if (got !== exp) begin
			report_failure($sformatf("MISMATCH time=%0t %s got=%h expected=%h",
				$time, name, got, exp));
		end
	endtask

	task automatic check_latency(string name, int unsigned got, int unsigned exp);
		if (got != exp) begin
			report_failure($sformatf("MISMATCH time=%0t %s got=%0d expected=%0d",
				$time, name, got, exp));
		end
	endtask

	task automatic expect_idle();
		check_sel("dev_rd", dev_rd, '0);
		check_sel("dev_wr", dev_wr, '0);
		check_data("io_done", io_data_t'(io_done), '0);
	endtask

	// ------------------------------------------------------------
	// Stimulus
	// ------------------------------------------------------------
	task automatic build_vectors();
		vector_t v;
		io_addr_t last;
		foreach (windows[w]) begin
			last = windows[w].base + (16'd1 << windows[w].bits) - 16'd1;
			vectors.push_back(make_vec(windows[w].base, 1'b0, $urandom));
			vectors.push_back(make_vec(last, 1'b0, $urandom));
			vectors.push_back(make_vec(last, 1'b1, $urandom));
		end
		vectors.push_back(make_vec(16'h0100, 1'b0, $urandom));
		vectors.push_back(make_vec(16'h02F8, 1'b0, $urandom));
		vectors.push_back(make_vec(16'hFFFF, 1'b0, $urandom));
		vectors.push_back(make_vec(16'h02F8, 1'b1, $urandom));
		for (int i = 0; i < 8; i++) begin
			v = make_vec(io_addr_t'($urandom), 1'b0, $urandom);
			if (v.dev < 0) begin
				vectors.push_back(v); // Keep only the unmapped ones
			end
		end
	endtask

	task automatic run_single(vector_t v);
		dev_sel_t seen_rd;
		dev_sel_t seen_wr;
		int unsigned t0;
		int unsigned n;
		seen_rd = '0;
		seen_wr = '0;
		n = 0;
		@(negedge clk_sys);
		io_req_valid = 1'b1;
		io_req = '{addr: v.addr, write: v.write, wdata: v.wdata};
		t0 = cycle_cnt;
		do begin
			@(negedge clk_sys);
			io_req_valid = 1'b0;
			seen_rd |= dev_rd;
			seen_wr |= dev_wr;
			n++;
			if (n > TIMEOUT_CYCLES) begin
				report_failure($sformatf("TIMEOUT: no io_done for port %h", v.addr));
			end
		end while (!io_done);
		check_latency("io_done latency", cycle_cnt - t0, `IO_DONE_LATENCY);
		check_sel("dev_rd", seen_rd, v.write ? '0 : onehot(v.dev));
		check_sel("dev_wr", seen_wr, v.write ? onehot(v.dev) : '0);
		check_cmd("dev_cmd", dev_cmd, '{addr: v.addr, wdata: v.wdata});
		check_data("io_rsp.rdata", io_rsp.rdata, v.rdata);
	endtask

	task automatic run_burst(int count);
		vector_t vecs[$];
		int unsigned c0;
		int unsigned n;
		int k;
		int done_idx;
		for (int i = 0; i < count; i++) begin
			vecs.push_back(random_vec());
		end
		n = 0;
		done_idx = 0;
		@(negedge clk_sys);
		c0 = cycle_cnt;
		fork
			begin
				for (int j = 0; j < count; j++) begin
					io_req_valid = 1'b1;
					io_req = '{addr: vecs[j].addr, write: vecs[j].write, wdata: vecs[j].wdata};
					@(negedge clk_sys);
				end
				io_req_valid = 1'b0;
			end
			begin
				while (done_idx < count) begin
					@(negedge clk_sys);
					k = int'(cycle_cnt - c0) - (`IO_DONE_LATENCY - 1); // Request now on the strobes
					if (k >= 0 && k < count) begin
						check_sel("dev_rd", dev_rd, vecs[k].write ? '0 : onehot(vecs[k].dev));
						check_sel("dev_wr", dev_wr, vecs[k].write ? onehot(vecs[k].dev) : '0);
						check_cmd("dev_cmd", dev_cmd, '{addr: vecs[k].addr, wdata: vecs[k].wdata});
					end else begin
						check_sel("dev_rd", dev_rd, '0);
						check_sel("dev_wr", dev_wr, '0);
					end
					if (io_done) begin
						check_latency("io_done cycle", cycle_cnt - c0, done_idx + `IO_DONE_LATENCY);
						check_data("io_rsp.rdata", io_rsp.rdata, vecs[done_idx].rdata);
						done_idx++;
					end
					n++;
					if (n > count + TIMEOUT_CYCLES) begin
						report_failure("TIMEOUT: burst responses did not all arrive");
					end
				end
			end
		join
	endtask

	initial begin
		void'($urandom(32'h31fc_923a));
		rst_n = 1'b1;
		io_req_valid = 1'b0;
		io_req = '0;
		for (int i = 0; i < DEV_COUNT; i++) begin
			dev_rdata[i] = dev_word(i);
		end
		#1 rst_n = 1'b0;
		for (int i = 0; i < 10; i++) begin
			@(negedge clk_sys);
			expect_idle();
		end
		rst_n = 1'b1;
		for (int i = 0; i < 3; i++) begin
			@(negedge clk_sys);
			expect_idle();
		end

		build_vectors();
		foreach (vectors[i]) begin
			run_single(vectors[i]);
		end
		run_burst(BURST_LEN);
		repeat (4) @(negedge clk_sys);

		if (err_cnt == 0) begin
			$display("ALL TESTS PASSED");
			$finish;
		end else begin
			report_failure("errors were recorded during the run");
		end
	end

endmodule

`default_nettype wire

//--- io_read_router.sv
`timescale 1ns/1ps
`default_nettype none

`include "iobus_consts.svh"

module io_read_router
	import iobus_pkg::*;
(
	input  wire logic       clk_sys,
	input  wire logic       rst_n,

	input  wire logic       s2_valid,
	input  wire logic       s2_write,
	input  wire dev_sel_t   s2_sel,

	input  wire dev_rdata_t dev_rdata,

	output logic            io_done,
	output io_rsp_t         io_rsp
);

	io_data_t rdata_d;

	// Only the IDE data ports are 32 bits wide
	function automatic logic is_wide(dev_id_e id);
		return (id == DEV_HDD0) || (id == DEV_HDD1);
	endfunction

	// ------------------------------------------------------------
	// Read data select
	// ------------------------------------------------------------
	always_comb begin
		rdata_d = {24'd0, `IO_UNMAPPED_BYTE};

		// Walk from lowest priority up so the lowest dev_id_e wins
		for (int i = DEV_COUNT - 1; i >= 0; i--) begin
			if (s2_sel[i]) begin
				if (is_wide(dev_id_e'(i))) begin
					rdata_d = dev_rdata[i];
				end else begin
					rdata_d = {24'd0, io_byte_t'(dev_rdata[i][7:0])};
				end
			end
		end
	end

	// ------------------------------------------------------------
	// Response register
	// ------------------------------------------------------------
	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			io_done <= 1'b0;
		end else begin
			io_done <= s2_valid;
		end
	end

	always_ff @(posedge clk_sys) begin
		io_rsp.rdata <= s2_write ? '0 : rdata_d; // Writes answer with zero
	end

endmodule

`default_nettype wire

//--- iobus_consts.svh
`ifndef IOBUS_CONSTS_SVH
`define IOBUS_CONSTS_SVH

// ------------------------------------------------------------
// Port windows, base address and size as low address bits
// ------------------------------------------------------------
`define IO_BASE_HDD0        16'h01F0
`define IO_BITS_HDD0        3
`define IO_BASE_HDD1        16'h0170
`define IO_BITS_HDD1        3
`define IO_BASE_FLOPPY      16'h03F0
`define IO_BITS_FLOPPY      3
`define IO_BASE_HDD1_EXT    16'h0370
`define IO_BITS_HDD1_EXT    3
`define IO_BASE_DMA_SLAVE   16'h0000
`define IO_BITS_DMA_SLAVE   4
`define IO_BASE_DMA_PAGE    16'h0080
`define IO_BITS_DMA_PAGE    4
`define IO_BASE_DMA_MASTER  16'h00C0
`define IO_BITS_DMA_MASTER  5
`define IO_BASE_PIC_MASTER  16'h0020
`define IO_BITS_PIC_MASTER  1
`define IO_BASE_PIC_SLAVE   16'h00A0
`define IO_BITS_PIC_SLAVE   1
`define IO_BASE_PIT         16'h0040
`define IO_BITS_PIT         2
`define IO_BASE_PS2_IO      16'h0060
`define IO_BITS_PS2_IO      3
`define IO_BASE_PS2_CTL     16'h0090
`define IO_BITS_PS2_CTL     4
`define IO_BASE_RTC         16'h0070
`define IO_BITS_RTC         1
`define IO_BASE_SB          16'h0220
`define IO_BITS_SB          4
`define IO_BASE_FM          16'h0388
`define IO_BITS_FM          2
`define IO_BASE_UART        16'h03F8
`define IO_BITS_UART        3
`define IO_BASE_MPU         16'h0330
`define IO_BITS_MPU         1
`define IO_BASE_VGA_B       16'h03B0
`define IO_BITS_VGA_B       4
`define IO_BASE_VGA_C       16'h03C0
`define IO_BITS_VGA_C       4
`define IO_BASE_VGA_D       16'h03D0
`define IO_BITS_VGA_D       4
`define IO_BASE_JOY         16'h0201
`define IO_BITS_JOY         0

// ------------------------------------------------------------
// Bus behavior
// ------------------------------------------------------------
`define IO_UNMAPPED_BYTE    8'hFF
`define IO_DONE_LATENCY     3

`endif

//--- iobus_pkg.sv
`default_nettype none

package iobus_pkg;

	localparam int unsigned DEV_COUNT = 13;

	typedef logic [15:0] io_addr_t;
	typedef logic [31:0] io_data_t;
	typedef logic [7:0]  io_byte_t;

	// ------------------------------------------------------------
	// Devices in read priority order
	// ------------------------------------------------------------
	typedef enum logic [3:0] {
		DEV_HDD0     = 4'd0,
		DEV_HDD1     = 4'd1,
		DEV_FLOPPY   = 4'd2,
		DEV_HDD1_EXT = 4'd3,
		DEV_DMA      = 4'd4,
		DEV_PIC      = 4'd5,
		DEV_PIT      = 4'd6,
		DEV_PS2      = 4'd7,
		DEV_RTC      = 4'd8,
		DEV_SOUND    = 4'd9,
		DEV_UART     = 4'd10,
		DEV_VGA      = 4'd11,
		DEV_JOY      = 4'd12
	} dev_id_e;

	typedef logic [DEV_COUNT-1:0] dev_sel_t; // One bit per dev_id_e

	typedef struct packed {
		io_addr_t addr;
		logic     write;
		io_data_t wdata;
	} io_req_t;

	// Shared by all devices, qualified by the per-device strobes
	typedef struct packed {
		io_addr_t addr;
		io_data_t wdata;
	} dev_cmd_t;

	typedef io_data_t [DEV_COUNT-1:0] dev_rdata_t; // Indexed by dev_id_e

	typedef struct packed {
		io_data_t rdata;
	} io_rsp_t;

endpackage

`default_nettype wire

//--- tb_clock_gen.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen (
	output logic clk_sys
);

	initial begin
		clk_sys = 1'b0;
		forever begin
			#2 clk_sys = ~clk_sys; // 4 ns period
		end
	end

endmodule

`default_nettype wire
